// ==== axi_wr_tests.txt ====
// Burst line: id addr len size burst resp, then len+1 beat lines
// Beat line: data strb expected_addr expected_boundary_err, ffffffff ends the list
1 0100 00 2 1 0
a1000000 f 0100 0
2 0200 07 2 1 0
b2000000 f 0200 0
b2000001 f 0204 0
b2000002 3 0208 0
b2000003 f 020c 0
b2000004 c 0210 0
b2000005 f 0214 0
b2000006 f 0218 0
b2000007 8 021c 0
3 0301 03 0 1 0
c3000011 2 0301 0
c3002200 4 0302 0
c3330000 8 0303 0
c3000044 1 0304 0
4 0403 02 1 1 0
d4440000 8 0403 0
d4000055 3 0404 0
d4660000 c 0406 0
5 0500 02 2 0 0
e5000001 f 0500 0
e5000002 f 0500 0
e5000003 f 0500 0
6 0ff8 03 2 1 0
f6000001 f 0ff8 0
f6000002 f 0ffc 0
f6000003 f 0ffc 1
f6000004 f 0ffc 1
7 0702 01 3 1 2
17000001 f 0702 0
17000002 f 0708 0
8 0805 01 2 2 0
28000001 e 0805 0
28000002 f 0808 0
9 1000 03 2 1 0
39000001 f 1000 0
39000002 f 1004 0
39000003 f 1008 0
39000004 f 100c 0
ffffffff

// ==== sim.f ====
axi_wr_pkg.sv
sync_fifo.sv
wr_addr_gen.sv
wr_burst_ctrl.sv
axi_wr_slave.sv
tb_clk_gen.sv
tb_checker.sv
tb_axi_wr_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AXI write slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_axi_wr_slave -o tb_axi_wr_slave_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_axi_wr_slave_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

// ==== tb_axi_wr_slave.sv ====
`timescale 1ns/1ps

module tb_axi_wr_slave
    import axi_wr_pkg::*;
();

    localparam string       TEST_FILE   = "axi_wr_tests.txt";
    localparam int          TEST_WORDS  = 512;
    localparam logic [31:0] END_MARK    = 32'hffff_ffff;
    localparam logic [31:0] RANDOM_SEED = 32'h32e7_6fd8;
    // Words in a burst line and in a beat line
    localparam int          BURST_WORDS = 6;
    localparam int          BEAT_WORDS  = 4;

    logic clk;
    logic rst_n;

    // DUT inputs, all idle from time zero
    aw_req_t aw         = '0;
    logic    aw_valid   = 1'b0;
    w_beat_t w          = '0;
    logic    w_valid    = 1'b0;
    logic    b_ready    = 1'b0;
    logic    mem_credit = 1'b0;

    logic    aw_ready;
    logic    w_ready;
    b_resp_t b;
    logic    b_valid;
    mem_wr_t mem;
    logic    mem_we;

    logic [31:0] tests [TEST_WORDS];
    int          n_beats   = 0;
    int          limit     = 0;
    int          cycle     = 0;
    int          tick      = 0;
    int          hold_left = 0;
    // Cycle at which each received beat hands its credit back
    int          credit_due [$];
    logic        run_end   = 1'b0;
    logic        all_done;
    int          error_total;

    tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    axi_wr_slave axi_wr_slave_i (
        .clk(clk), .rst_n(rst_n),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .mem(mem), .mem_we(mem_we), .mem_credit(mem_credit)
    );

    tb_checker checker_i (
        .clk(clk), .rst_n(rst_n),
        .mem(mem), .mem_we(mem_we), .mem_credit(mem_credit),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .run_end(run_end), .done(all_done), .error_total(error_total)
    );

    // --------------------------------------------------
    // AW and W masters, independent so W can run ahead
    // --------------------------------------------------
    task automatic send_addresses();
        int idx;
        int len;
        idx = 0;
        while (idx < TEST_WORDS - BURST_WORDS && tests[idx] != END_MARK) begin
            len      = int'(tests[idx + 2][LEN_W-1:0]);
            aw_valid <= 1'b0;
            repeat ($urandom_range(2)) @(posedge clk);
            aw <= '{id:    tests[idx][ID_W-1:0],
                    addr:  tests[idx + 1][ADDR_W-1:0],
                    len:   tests[idx + 2][LEN_W-1:0],
                    size:  tests[idx + 3][SIZE_W-1:0],
                    burst: burst_e'(tests[idx + 4][1:0])};
            aw_valid <= 1'b1;
            // Hold until the slave takes it
            @(posedge clk);
            while (!aw_ready) @(posedge clk);
            idx += BURST_WORDS + BEAT_WORDS * (len + 1);
        end
        aw_valid <= 1'b0;
    endtask

    task automatic send_data();
        int idx;
        int len;
        int beat;
        int pos;
        idx = 0;
        while (idx < TEST_WORDS - BURST_WORDS && tests[idx] != END_MARK) begin
            len = int'(tests[idx + 2][LEN_W-1:0]);
            for (beat = 0; beat <= len; beat++) begin
                pos     = idx + BURST_WORDS + BEAT_WORDS * beat;
                w_valid <= 1'b0;
                repeat ($urandom_range(1)) @(posedge clk);
                w <= '{data: tests[pos],
                       strb: tests[pos + 1][STRB_W-1:0],
                       last: (beat == len)};
                w_valid <= 1'b1;
                @(posedge clk);
                while (!w_ready) @(posedge clk);
            end
            idx += BURST_WORDS + BEAT_WORDS * (len + 1);
        end
        w_valid <= 1'b0;
    endtask

    // --------------------------------------------------
    // Memory sink and B stalls
    // --------------------------------------------------
    // One credit back per beat, 0 to 3 cycles late
    always @(posedge clk) begin
        if (rst_n) begin
            tick++;
            if (mem_we) begin
                credit_due.push_back(tick + int'($urandom_range(3)));
            end
            if (credit_due.size() != 0 && credit_due[0] <= tick) begin
                mem_credit <= 1'b1;
                void'(credit_due.pop_front());
            end else begin
                mem_credit <= 1'b0;
            end
        end
    end

    // Random runs of ready and stall, long enough to fill the B FIFO
    always @(posedge clk) begin
        if (rst_n) begin
            if (hold_left == 0) begin
                b_ready   <= ($urandom_range(2) != 0);
                hold_left = int'($urandom_range(12, 1));
            end else begin
                hold_left--;
            end
        end
    end

    // --------------------------------------------------
    // Run control
    // --------------------------------------------------
    initial begin : run_tests
        int   idx;
        logic timed_out;
        void'($urandom(RANDOM_SEED));
        $readmemh(TEST_FILE, tests);
        idx = 0;
        while (idx < TEST_WORDS - BURST_WORDS && tests[idx] != END_MARK) begin
            n_beats += int'(tests[idx + 2][LEN_W-1:0]) + 1;
            idx     += BURST_WORDS + BEAT_WORDS * (int'(tests[idx + 2][LEN_W-1:0]) + 1);
        end
        if (n_beats == 0) begin
            $display("No bursts could be read from %s", TEST_FILE);
        end
        limit = 40 * n_beats + 200;

        wait (rst_n);
        fork
            send_addresses();
            send_data();
        join_none

        while (!all_done && cycle < limit) begin
            @(posedge clk);
            cycle++;
        end
        timed_out = !all_done;
        if (timed_out) begin
            $display("Timeout: responses still missing after %0d cycles", cycle);
        end

        // Closing line comes from the checker
        run_end <= 1'b1;
        @(negedge clk);
        if (!timed_out && error_total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker
    import axi_wr_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  mem_wr_t mem,
    input  logic    mem_we,
    input  logic    mem_credit,
    input  b_resp_t b,
    input  logic    b_valid,
    input  logic    b_ready,
    input  logic    run_end,
    output logic    done,
    output int      error_total
);

    localparam string       TEST_FILE   = "axi_wr_tests.txt";
    localparam int          TEST_WORDS  = 512;
    localparam logic [31:0] END_MARK    = 32'hffff_ffff;
    localparam int          BURST_WORDS = 6;
    localparam int          BEAT_WORDS  = 4;

    logic [31:0] tests [TEST_WORDS];
    // Expected traffic in issue order
    mem_wr_t     exp_beats [$];
    b_resp_t     exp_resps [$];
    int          n_resps    = 0;
    int          beats_seen = 0;
    int          resps_seen = 0;
    // Beats on the memory port not yet answered by a credit
    int          in_flight  = 0;
    int          value_errs = 0;
    int          proto_errs = 0;

    assign done        = (n_resps != 0) && (resps_seen >= n_resps);
    assign error_total = value_errs + proto_errs;

    // --------------------------------------------------
    // Expected values from the tests file
    // --------------------------------------------------
    initial begin : load_expected
        int      idx;
        int      len;
        int      beat;
        int      pos;
        mem_wr_t want;
        b_resp_t rsp;
        $readmemh(TEST_FILE, tests);
        idx = 0;
        while (idx < TEST_WORDS - BURST_WORDS && tests[idx] != END_MARK) begin
            len      = int'(tests[idx + 2][LEN_W-1:0]);
            rsp.id   = tests[idx][ID_W-1:0];
            rsp.resp = resp_e'(tests[idx + 5][1:0]);
            exp_resps.push_back(rsp);
            for (beat = 0; beat <= len; beat++) begin
                pos               = idx + BURST_WORDS + BEAT_WORDS * beat;
                want.id           = tests[idx][ID_W-1:0];
                want.addr         = tests[pos + 2][ADDR_W-1:0];
                want.data         = tests[pos];
                want.strb         = tests[pos + 1][STRB_W-1:0];
                // WLAST only on the final beat of the burst
                want.last         = (beat == len);
                want.boundary_err = tests[pos + 3][0];
                exp_beats.push_back(want);
            end
            idx += BURST_WORDS + BEAT_WORDS * (len + 1);
        end
        n_resps = exp_resps.size();
    end

    // --------------------------------------------------
    // Comparison
    // --------------------------------------------------
    task automatic match_field(input string name, input int item,
                               input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL %s, item %0d: got %h, expected %h", name, item, got, want);
            value_errs++;
        end
    endtask

    task automatic beat_arrived();
        mem_wr_t want;
        if (exp_beats.size() == 0) begin
            $display("A beat to address %h arrived after all expected beats", mem.addr);
            proto_errs++;
        end else begin
            want = exp_beats.pop_front();
            match_field("mem.id", beats_seen, mem.id, want.id);
            match_field("mem.addr", beats_seen, mem.addr, want.addr);
            match_field("mem.data", beats_seen, mem.data, want.data);
            match_field("mem.strb", beats_seen, mem.strb, want.strb);
            match_field("mem.last", beats_seen, mem.last, want.last);
            match_field("mem.boundary_err", beats_seen, mem.boundary_err,
                        want.boundary_err);
        end
        beats_seen++;
    endtask

    task automatic response_arrived();
        b_resp_t want;
        if (exp_resps.size() == 0) begin
            $display("A response with id %h arrived after the last burst", b.id);
            proto_errs++;
        end else begin
            want = exp_resps.pop_front();
            // Id order doubles as the in-order check
            match_field("b.id", resps_seen, b.id, want.id);
            match_field("b.resp", resps_seen, b.resp, want.resp);
        end
        resps_seen++;
    endtask

    // Sampled on the edge, so the values are the ones the DUT registered
    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_we) begin
                beat_arrived();
            end
            if (b_valid && b_ready) begin
                response_arrived();
            end
            in_flight = in_flight + int'(mem_we) - int'(mem_credit);
            if (in_flight > MEM_CREDITS) begin
                $display("%0d beats outstanding on the memory port, more than %0d credits",
                         in_flight, MEM_CREDITS);
                proto_errs++;
            end
        end
    end

    // --------------------------------------------------
    // Closing report
    // --------------------------------------------------
    always @(posedge run_end) begin
        if (exp_beats.size() != 0) begin
            $display("%0d expected beats never reached the memory port", exp_beats.size());
            proto_errs++;
        end
        if (exp_resps.size() != 0) begin
            $display("%0d expected responses never arrived on B", exp_resps.size());
            proto_errs++;
        end
        $display("Checked %0d beats and %0d responses: %0d value errors, %0d other errors",
                 beats_seen, resps_seen, value_errs, proto_errs);
    end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset released on a rising edge so the DUT sees a clean deassertion
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== axi_wr_slave.sv ====
`timescale 1ns/1ps

module axi_wr_slave
    import axi_wr_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    // AW channel
    input  aw_req_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,
    // W channel
    input  w_beat_t w,
    input  logic    w_valid,
    output logic    w_ready,
    // B channel
    output b_resp_t b,
    output logic    b_valid,
    input  logic    b_ready,
    // Memory side
    output mem_wr_t mem,
    output logic    mem_we,
    input  logic    mem_credit
);

    aw_req_t           aw_head;
    logic              aw_full;
    logic              aw_empty;
    logic              aw_pop;
    w_beat_t           w_head;
    logic              w_full;
    logic              w_empty;
    logic              w_pop;
    b_resp_t           b_data;
    logic              b_full;
    logic              b_empty;
    logic              b_push;
    aw_req_t           desc;
    logic              first;
    logic [ADDR_W-1:0] cur_addr;
    logic [ADDR_W-1:0] next_addr;
    logic              page_cross;
    resp_e             resp;

    // Ready and valid straight from the buffer flags
    assign aw_ready = !aw_full;
    assign w_ready  = !w_full;
    assign b_valid  = !b_empty;

    // --------------------------------------------------
    // Channel buffers
    // --------------------------------------------------
    sync_fifo #(.WIDTH($bits(aw_req_t)), .DEPTH(AW_DEPTH)) aw_buf (
        .clk(clk), .rst_n(rst_n),
        .push(aw_valid && aw_ready), .din(aw),
        .pop(aw_pop), .dout(aw_head),
        .full(aw_full), .empty(aw_empty)
    );

    sync_fifo #(.WIDTH($bits(w_beat_t)), .DEPTH(W_DEPTH)) w_buf (
        .clk(clk), .rst_n(rst_n),
        .push(w_valid && w_ready), .din(w),
        .pop(w_pop), .dout(w_head),
        .full(w_full), .empty(w_empty)
    );

    // Responses leave in burst order
    sync_fifo #(.WIDTH($bits(b_resp_t)), .DEPTH(B_DEPTH)) b_buf (
        .clk(clk), .rst_n(rst_n),
        .push(b_push), .din(b_data),
        .pop(b_valid && b_ready), .dout(b),
        .full(b_full), .empty(b_empty)
    );

    // --------------------------------------------------
    // Burst engine
    // --------------------------------------------------
    wr_burst_ctrl ctrl (
        .clk(clk), .rst_n(rst_n),
        .aw_head(aw_head), .aw_empty(aw_empty), .aw_pop(aw_pop),
        .w_head(w_head), .w_empty(w_empty), .w_pop(w_pop),
        .b_full(b_full), .b_push(b_push), .b_data(b_data),
        .next_addr(next_addr), .page_cross(page_cross), .resp(resp),
        .desc(desc), .first(first), .cur_addr(cur_addr),
        .mem(mem), .mem_we(mem_we), .mem_credit(mem_credit)
    );

    wr_addr_gen addr_gen (
        .desc(desc), .first(first), .cur_addr(cur_addr),
        .next_addr(next_addr), .page_cross(page_cross), .resp(resp)
    );

endmodule

// ==== wr_burst_ctrl.sv ====
`timescale 1ns/1ps

module wr_burst_ctrl
    import axi_wr_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // AW buffer
    input  aw_req_t           aw_head,
    input  logic              aw_empty,
    output logic              aw_pop,
    // W buffer
    input  w_beat_t           w_head,
    input  logic              w_empty,
    output logic              w_pop,
    // B buffer
    input  logic              b_full,
    output logic              b_push,
    output b_resp_t           b_data,
    // Address generator
    input  logic [ADDR_W-1:0] next_addr,
    input  logic              page_cross,
    input  resp_e             resp,
    output aw_req_t           desc,
    output logic              first,
    output logic [ADDR_W-1:0] cur_addr,
    // Memory side
    output mem_wr_t           mem,
    output logic              mem_we,
    input  logic              mem_credit
);

    burst_phase_e        state;
    burst_phase_e        state_nxt;
    aw_req_t             desc_q;
    logic [LEN_W-1:0]    beat_cnt;
    logic [ADDR_W-1:0]   beat_addr;
    logic                cross_q;
    logic [CREDIT_W-1:0] credit_cnt;
    logic                credit_ok;
    logic                burst_end;

    // --------------------------------------------------
    // Beat issue
    // --------------------------------------------------
    assign first     = (state == BP_FIRST);
    assign credit_ok = (credit_cnt != '0);

    // The head of AW drives the first beat before it is latched
    assign desc     = first ? aw_head : desc_q;
    assign cur_addr = beat_addr;

    // First beat also needs a descriptor while later beats need only data and credit
    assign mem_we = credit_ok && !w_empty &&
                    ((first && !aw_empty) || state == BP_BURST);
    assign w_pop  = mem_we;
    assign aw_pop = mem_we && first;

    // Last beat counted against len with the beat index running from 0
    assign burst_end = mem_we && (first ? (aw_head.len == '0) : (beat_cnt == desc_q.len));

    always_comb begin
        mem.id           = desc.id;
        // Raw start address on the first beat and the generated address after
        mem.addr         = first ? desc.addr : beat_addr;
        mem.data         = w_head.data;
        mem.strb         = w_head.strb;
        mem.last         = w_head.last;
        mem.boundary_err = !first && cross_q;
    end

    // --------------------------------------------------
    // Response push
    // --------------------------------------------------
    // Pushed with the last beat, or later from BRESP once there is room
    assign b_push      = !b_full && (burst_end || state == BP_BRESP);
    assign b_data.id   = desc.id;
    assign b_data.resp = resp;

    // --------------------------------------------------
    // State machine
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            BP_FIRST: begin
                if (burst_end) begin
                    state_nxt = b_full ? BP_BRESP : BP_FIRST;
                end else if (mem_we) begin
                    state_nxt = BP_BURST;
                end
            end
            BP_BURST: begin
                if (burst_end) begin
                    state_nxt = b_full ? BP_BRESP : BP_FIRST;
                end
            end
            BP_BRESP: state_nxt = b_full ? BP_BRESP : BP_FIRST;
            BP_IDLE:  state_nxt = BP_FIRST;
            default:  state_nxt = BP_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= BP_IDLE;
            beat_cnt   <= '0;
            cross_q    <= 1'b0;
            credit_cnt <= CREDIT_W'(MEM_CREDITS);
        end else begin
            state <= state_nxt;
            if (mem_we) begin
                beat_cnt <= first ? LEN_W'(1) : beat_cnt + 1'b1;
                // Sticky within a burst since a clamped address keeps crossing
                cross_q  <= page_cross;
            end
            // Spend one per beat and regain one per returned credit
            credit_cnt <= credit_cnt - CREDIT_W'(mem_we) + CREDIT_W'(mem_credit);
        end
    end

    // Descriptor and beat address
    always_ff @(posedge clk) begin
        if (aw_pop) begin
            desc_q <= aw_head;
        end
        if (mem_we) begin
            beat_addr <= next_addr;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    // A spent credit lowers the count and never wraps below zero
    a_no_beat_without_credit: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we && !mem_credit |=> credit_cnt < $past(credit_cnt));

    // Sink must not return more credits than beats it received
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        int'(credit_cnt) <= MEM_CREDITS);

    // Master's WLAST has to agree with AWLEN
    a_wlast_matches_len: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we |-> (w_head.last == burst_end));

endmodule

// ==== wr_addr_gen.sv ====
`timescale 1ns/1ps

module wr_addr_gen
    import axi_wr_pkg::*;
(
    input  aw_req_t           desc,
    input  logic              first,
    input  logic [ADDR_W-1:0] cur_addr,
    output logic [ADDR_W-1:0] next_addr,
    output logic              page_cross,
    output resp_e             resp
);

    logic [ADDR_W-1:0] align_mask;
    logic [ADDR_W-1:0] aligned_addr;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] step;
    // Carry bit kept so a wrap past the top of the map counts as a crossing
    logic [ADDR_W:0]   sum;
    logic              size_err;

    // --------------------------------------------------
    // Alignment
    // --------------------------------------------------
    // Clear the low size bits of the start address
    assign align_mask   = {ADDR_W{1'b1}} << desc.size;
    assign aligned_addr = desc.addr & align_mask;

    // First beat steps from the aligned start, later beats from the last address
    assign base = first ? aligned_addr : cur_addr;

    // --------------------------------------------------
    // Increment
    // --------------------------------------------------
    // FIXED repeats the address
    // INCR, WRAP and RSVD all advance by the transfer size
    always_comb begin
        if (desc.burst == BURST_FIXED) begin
            step = '0;
        end else begin
            step = ADDR_W'(1) << desc.size;
        end
    end

    assign sum = {1'b0, base} + {1'b0, step};

    // --------------------------------------------------
    // 4 KB guard
    // --------------------------------------------------
    // Page is judged against the burst start, not the current beat
    assign page_cross = (sum[ADDR_W:PAGE_BIT] != {1'b0, desc.addr[ADDR_W-1:PAGE_BIT]});

    // Hold the address inside the page once the step would leave it
    assign next_addr = page_cross ? base : sum[ADDR_W-1:0];

    // --------------------------------------------------
    // Response
    // --------------------------------------------------
    // Beats wider than the data bus are still written, but the burst fails
    assign size_err = (desc.size > SIZE_W'(MAX_SIZE));
    assign resp     = size_err ? RESP_SLVERR : RESP_OKAY;

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    // Entry storage
    logic [WIDTH-1:0] mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    // One extra bit so a full FIFO can be told from an empty one
    logic [$clog2(DEPTH):0]   count;

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Explicit wrap keeps non power-of-two depths correct
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

    // Show-ahead head is valid whenever empty is low
    assign dout  = mem[rd_ptr];
    assign full  = (int'(count) == DEPTH);
    assign empty = (count == '0);

    // Callers must respect the flags on both sides
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && full) && !(pop && empty));

endmodule

// ==== axi_wr_pkg.sv ====
package axi_wr_pkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------
    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;
    localparam int ADDR_W   = 16;
    localparam int ID_W     = 4;
    localparam int LEN_W    = 8;
    localparam int SIZE_W   = 3;
    // Largest legal AWSIZE, log2 of the byte lanes
    localparam int MAX_SIZE = $clog2(STRB_W);
    // Address bit that selects the 4 KB page
    localparam int PAGE_BIT = 12;

    // --------------------------------------------------
    // Buffer depths and memory-side credits
    // --------------------------------------------------
    localparam int AW_DEPTH    = 4;
    localparam int W_DEPTH     = 16;
    localparam int B_DEPTH     = 4;
    localparam int MEM_CREDITS = 4;
    localparam int CREDIT_W    = $clog2(MEM_CREDITS + 1);

    // AXI burst type, WRAP and RSVD are stepped like INCR
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11
    } burst_e;

    // Only OKAY and SLVERR are ever returned
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // Controller phases
    typedef enum logic [1:0] {
        BP_FIRST = 2'b00,
        BP_BURST = 2'b01,
        BP_BRESP = 2'b10,
        BP_IDLE  = 2'b11
    } burst_phase_e;

    // --------------------------------------------------
    // Channel payloads
    // --------------------------------------------------
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [SIZE_W-1:0] size;
        burst_e            burst;
    } aw_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } b_resp_t;

    // One beat on the memory-side write port
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
        logic              boundary_err;
    } mem_wr_t;

endpackage
